/* eth_patterns.txt */
4 0 1 0
3 1 1 1
3 1 0 0
130 0 1 0
4 1 1 1

/* project.f */
+incdir+.
eth_example_pkg.sv
axis_if.sv
frame_gen.sv
frame_check.sv
stats_serializer.sv
eth_example_top.sv
tb_clock.sv
eth_example_props.sv
eth_example_tb.sv

/* Makefile */
# Verilator build and run of the Ethernet example testbench

TOP = eth_example_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -o sim
	./obj_dir/sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* eth_example_tb.sv */
// loopback testbench with pattern file phases, frame model, stats decoder and timeout
`timescale 1ns/100ps
`include "eth_example_config.svh"

module eth_example_tb;

   logic                        tx_clk0;
   logic                        reset;
   logic                        enable_pat_gen = 1'b0;
   logic                        enable_pat_check = 1'b0;
   logic                        insert_error = 1'b0;
   logic                        reset_error = 1'b0;
   logic                        ready_bit = 1'b0;
   logic [31:0]                 lfsr = 32'd98267;
   eth_example_pkg::axis_data_t tx_tdata;
   eth_example_pkg::axis_keep_t tx_tkeep;
   logic                        tx_tvalid;
   logic                        tx_tlast;
   logic                        tx_tready;
   eth_example_pkg::axis_data_t rx_tdata;
   eth_example_pkg::axis_keep_t rx_tkeep;
   logic                        rx_tvalid;
   logic                        rx_tlast;
   logic                        rx_tready;
   logic                        frame_error;
   logic                        tx_statistics_vector;

   // model and bookkeeping
   int                          model_size = `ETH_MIN_FRAME;
   int                          beat_cnt = 0;
   logic                        in_frame = 1'b0;
   logic                        cur_err = 1'b0;
   logic                        saw_max = 1'b0;
   logic                        saw_wrap = 1'b0;
   int                          frames_done = 0;
   int                          err_requests = 0;
   int                          err_taken = 0;
   int                          err_seen = 0;
   eth_example_pkg::tx_stats_t  exp_stats [1024];
   logic                        dec_busy = 1'b0;
   int                          dec_cnt = 0;
   eth_example_pkg::tx_stats_t  dec_word = '0;
   int                          stats_seen = 0;
   int                          data_errors = 0;
   int                          stats_errors = 0;
   int                          flag_errors = 0;
   int                          cycle_count = 0;
   int                          cycle_limit = 0;
   int                          ph_frames [16];
   logic                        ph_ins [16];
   logic                        ph_chk [16];
   logic                        ph_exp [16];

   tb_clock clk_i (
      .tx_clk0 (tx_clk0),
      .reset   (reset)
   );

   eth_example_top UUT (
      .tx_clk0              (tx_clk0),
      .reset                (reset),
      .enable_pat_gen       (enable_pat_gen),
      .enable_pat_check     (enable_pat_check),
      .insert_error         (insert_error),
      .reset_error          (reset_error),
      .tx_tdata             (tx_tdata),
      .tx_tkeep             (tx_tkeep),
      .tx_tvalid            (tx_tvalid),
      .tx_tlast             (tx_tlast),
      .tx_tready            (tx_tready),
      .rx_tdata             (rx_tdata),
      .rx_tkeep             (rx_tkeep),
      .rx_tvalid            (rx_tvalid),
      .rx_tlast             (rx_tlast),
      .rx_tready            (rx_tready),
      .frame_error          (frame_error),
      .tx_statistics_vector (tx_statistics_vector)
   );

   // --------------------------------------------------
   // loopback with random stalls
   // --------------------------------------------------
   // a beat is looped only in the cycle it is accepted
   assign tx_tready = ready_bit & rx_tready;
   assign rx_tdata  = tx_tdata;
   assign rx_tkeep  = tx_tkeep;
   assign rx_tlast  = tx_tlast;
   assign rx_tvalid = tx_tvalid & ready_bit;

   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   always @(posedge tx_clk0) begin : stall_source
      logic [31:0] next_state;
      next_state = lfsr_step(lfsr);
      lfsr      <= next_state;
      ready_bit <= next_state[0];
   end

   // expected frame byte at position pos of a frame of size bytes
   function automatic logic [7:0] model_byte(int size, int pos, logic err);
      logic [47:0] dest;
      logic [47:0] src;
      logic [7:0]  value;
      dest = `ETH_DEST_ADDR;
      src  = `ETH_SRC_ADDR;
      if (pos < 6) begin
         value = dest[8*pos +: 8];
      end else if (pos < 12) begin
         value = src[8*(pos-6) +: 8];
      end else if (pos == 12) begin
         value = 8'((size - 14) >> 8);
      end else if (pos == 13) begin
         value = 8'(size - 14);
      end else begin
         value = 8'(pos - 14);
         if (err && pos == 14) begin
            value = ~value;
         end
      end
      return value;
   endfunction

   // --------------------------------------------------
   // transmit beat monitor
   // --------------------------------------------------
   always @(posedge tx_clk0) begin : beat_monitor
      logic                        err_now;
      int                          beat;
      int                          got_size;
      eth_example_pkg::axis_data_t exp_data;
      eth_example_pkg::axis_data_t mask;
      eth_example_pkg::axis_keep_t exp_keep;
      logic                        exp_last;
      if (!reset && !rx_tready) begin
         data_errors++;
         $display("[FAIL] %0t: rx_tready low after reset", $time);
      end
      if (!reset && tx_tvalid && tx_tready) begin
         beat    = in_frame ? beat_cnt : 0;
         err_now = in_frame ? cur_err : (err_requests != err_taken);
         for (int b = 0; b < 8; b++) begin
            exp_keep[b]        = (8*beat + b) < model_size;
            mask[8*b +: 8]     = {8{exp_keep[b]}};
            exp_data[8*b +: 8] = exp_keep[b] ? model_byte(model_size, 8*beat + b, err_now)
                                             : 8'h00;
         end
         exp_last = (8*beat + 8) >= model_size;
         if ((tx_tdata & mask) != exp_data || tx_tkeep != exp_keep || tx_tlast != exp_last) begin
            data_errors++;
            $display("[FAIL] %0t: frame %0d beat %0d got %h/%h/%b, expected %h/%h/%b",
                     $time, frames_done, beat, tx_tdata, tx_tkeep, tx_tlast,
                     exp_data, exp_keep, exp_last);
         end
         // payload byte 0 is frame byte 14, lane 6 of beat 1
         if (beat == 1 && tx_tdata[8*6 +: 8] != model_byte(model_size, 14, 1'b0)) begin
            err_seen <= err_seen + 1;
         end
         if (tx_tlast) begin
            got_size                     = 8*beat + $countones(tx_tkeep);
            in_frame                     <= 1'b0;
            frames_done                  <= frames_done + 1;
            exp_stats[frames_done[9:0]]  <= {err_now, 15'(model_size)};
            model_size <= (model_size >= `ETH_MAX_FRAME) ? `ETH_MIN_FRAME : model_size + 1;
            if (got_size == `ETH_MAX_FRAME) begin
               saw_max <= 1'b1;
            end
            if (got_size == `ETH_MIN_FRAME && saw_max) begin
               saw_wrap <= 1'b1;
            end
         end else begin
            in_frame <= 1'b1;
            beat_cnt <= beat + 1;
         end
         cur_err <= err_now;
         if (!in_frame && err_now) begin
            err_taken <= err_taken + 1;
         end
      end
   end

   // --------------------------------------------------
   // serial statistics decoder
   // --------------------------------------------------
   always @(posedge tx_clk0) begin : stats_decode
      eth_example_pkg::tx_stats_t got;
      if (reset) begin
         dec_busy <= 1'b0;
         dec_cnt  <= 0;
      end else if (!dec_busy) begin
         // the leading 0 of the marker looks like idle, so wait for its 1
         if (tx_statistics_vector) begin
            dec_busy <= 1'b1;
            dec_cnt  <= 0;
         end
      end else begin
         got = {dec_word[14:0], tx_statistics_vector};
         dec_word <= got;
         dec_cnt  <= dec_cnt + 1;
         if (dec_cnt == 15) begin
            dec_busy   <= 1'b0;
            stats_seen <= stats_seen + 1;
            if (stats_seen >= frames_done) begin
               stats_errors++;
               $display("statistics word %h arrived with no finished frame to match", got);
            end else if (got != exp_stats[stats_seen[9:0]]) begin
               stats_errors++;
               $display("[FAIL] %0t: stats word %0d is %h, expected %h",
                        $time, stats_seen, got, exp_stats[stats_seen[9:0]]);
            end
         end
      end
   end

   always @(posedge tx_clk0) begin : run_limit
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         $display("run stopped at the cycle limit of %0d, %0d frames received",
                  cycle_limit, frames_done);
         $display("Test failures found");
         $finish;
      end
   end

   // --------------------------------------------------
   // phase sequencing
   // --------------------------------------------------
   initial begin : phase_driver
      int fd;
      int rc;
      int n;
      int frames;
      int ins;
      int chk;
      int exp_err;
      int target;
      fd = $fopen("eth_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open eth_patterns.txt for reading");
         $display("Test failures found");
         $finish;
      end else begin
         n  = 0;
         rc = $fscanf(fd, "%d %d %d %d\n", frames, ins, chk, exp_err);
         while (rc == 4 && n < 16) begin
            ph_frames[n] = frames;
            ph_ins[n]    = (ins != 0);
            ph_chk[n]    = (chk != 0);
            ph_exp[n]    = (exp_err != 0);
            cycle_limit += frames * (25 + `ETH_IFG_CYCLES + 40);
            n++;
            rc = $fscanf(fd, "%d %d %d %d\n", frames, ins, chk, exp_err);
         end
         $fclose(fd);
         cycle_limit += 200;

         @(posedge tx_clk0);
         while (reset) begin
            @(posedge tx_clk0);
         end
         target = 0;
         for (int p = 0; p < n; p++) begin
            target += ph_frames[p];
            enable_pat_gen   <= 1'b1;
            enable_pat_check <= ph_chk[p];
            insert_error     <= ph_ins[p];
            if (ph_ins[p]) begin
               err_requests <= err_requests + 1;
            end
            @(posedge tx_clk0);
            insert_error <= 1'b0;
            while (frames_done < target) begin
               @(posedge tx_clk0);
            end
            if (frame_error !== ph_exp[p]) begin
               flag_errors++;
               $display("[FAIL] %0t: phase %0d frame_error %b, expected %b",
                        $time, p, frame_error, ph_exp[p]);
            end
            // clear the sticky flag inside the inter-frame gap
            reset_error <= 1'b1;
            @(posedge tx_clk0);
            reset_error <= 1'b0;
            @(posedge tx_clk0);
            if (frame_error !== 1'b0) begin
               flag_errors++;
               $display("[FAIL] %0t: phase %0d frame_error not cleared by reset_error",
                        $time, p);
            end
         end

         // let a frame already under way finish and its stats drain
         enable_pat_gen <= 1'b0;
         repeat (2) @(posedge tx_clk0);
         while (in_frame || tx_tvalid || dec_busy || stats_seen < frames_done) begin
            @(posedge tx_clk0);
         end
         if (err_seen != err_requests) begin
            flag_errors++;
            $display("%0d error frames seen for %0d requests", err_seen, err_requests);
         end
         if (frames_done > `ETH_MAX_FRAME - `ETH_MIN_FRAME + 1 && !saw_wrap) begin
            flag_errors++;
            $display("frame size never wrapped from the maximum back to the minimum");
         end

         $display("frames %0d, data errors %0d, stats errors %0d, flag errors %0d",
                  frames_done, data_errors, stats_errors, flag_errors);
         if (data_errors + stats_errors + flag_errors == 0) begin
            $display("All tests passed!");
         end else begin
            $display("Test failures found");
         end
         $finish;
      end
   end

endmodule

/* eth_example_props.sv */
// concurrent assertions on the generator stream and their bind into frame_gen
`timescale 1ns/100ps

module eth_example_props (
   input logic                         tx_clk0,
   input logic                         reset,
   input eth_example_pkg::axis_data_t  tdata,
   input eth_example_pkg::axis_keep_t  tkeep,
   input logic                         tvalid,
   input logic                         tlast,
   input logic                         tready
);

   // a stalled beat stays on the bus unchanged
   hold_while_stalled: assert property (@(posedge tx_clk0) disable iff (reset)
      tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tkeep) && $stable(tlast))
      else $error("generator beat changed while the sink was stalling");

   // full keeps mid-frame, a contiguous run from bit 0 on the last beat
   keep_shape: assert property (@(posedge tx_clk0) disable iff (reset)
      tvalid |-> (tlast ? (tkeep[0] && (tkeep & (tkeep + 8'd1)) == 8'd0)
                        : tkeep == 8'hFF))
      else $error("generator tkeep %h not allowed with tlast %b", tkeep, tlast);

   quiet_after_reset: assert property (@(posedge tx_clk0)
      reset |=> !tvalid)
      else $error("generator tvalid high in the cycle after reset");

endmodule

bind frame_gen eth_example_props props_i (
   .tx_clk0 (tx_clk0),
   .reset   (reset),
   .tdata   (tx.tdata),
   .tkeep   (tx.tkeep),
   .tvalid  (tx.tvalid),
   .tlast   (tx.tlast),
   .tready  (tx.tready)
);

/* tb_clock.sv */
// testbench clock source and power-on reset
`timescale 1ns/100ps

module tb_clock (
   output logic tx_clk0,
   output logic reset
);

   localparam int HALF_PERIOD = 50;

   initial begin
      tx_clk0 = 1'b0;
      forever #HALF_PERIOD tx_clk0 = ~tx_clk0;
   end

   // reset held for the first two rising edges
   initial begin
      reset = 1'b1;
      repeat (2) @(posedge tx_clk0);
      reset <= 1'b0;
   end

endmodule

/* eth_example_top.sv */
// example top with pattern generator, pattern checker and stats serialiser
`timescale 1ns/100ps

module eth_example_top (
   input  logic                         tx_clk0,
   input  logic                         reset,
   input  logic                         enable_pat_gen,
   input  logic                         enable_pat_check,
   input  logic                         insert_error,
   input  logic                         reset_error,

   // transmit stream out
   output eth_example_pkg::axis_data_t  tx_tdata,
   output eth_example_pkg::axis_keep_t  tx_tkeep,
   output logic                         tx_tvalid,
   output logic                         tx_tlast,
   input  logic                         tx_tready,

   // receive stream in
   input  eth_example_pkg::axis_data_t  rx_tdata,
   input  eth_example_pkg::axis_keep_t  rx_tkeep,
   input  logic                         rx_tvalid,
   input  logic                         rx_tlast,
   output logic                         rx_tready,

   output logic                         frame_error,
   output logic                         tx_statistics_vector
);

   eth_example_pkg::tx_stats_t stats_word;
   logic                       stats_valid;

   axis_if gen_stream ();
   axis_if chk_stream ();

   // --------------------------------------------------
   // stream port mapping
   // --------------------------------------------------
   assign tx_tdata          = gen_stream.tdata;
   assign tx_tkeep          = gen_stream.tkeep;
   assign tx_tvalid         = gen_stream.tvalid;
   assign tx_tlast          = gen_stream.tlast;
   assign gen_stream.tready = tx_tready;

   assign chk_stream.tdata  = rx_tdata;
   assign chk_stream.tkeep  = rx_tkeep;
   assign chk_stream.tvalid = rx_tvalid;
   assign chk_stream.tlast  = rx_tlast;
   assign rx_tready         = chk_stream.tready;

   // --------------------------------------------------
   // instances
   // --------------------------------------------------
   frame_gen gen_i (
      .tx_clk0          (tx_clk0),
      .reset            (reset),
      .enable_pat_gen   (enable_pat_gen),
      .insert_error     (insert_error),
      .tx               (gen_stream.source),
      .stats_word       (stats_word),
      .stats_valid      (stats_valid)
   );

   frame_check check_i (
      .tx_clk0          (tx_clk0),
      .reset            (reset),
      .enable_pat_check (enable_pat_check),
      .reset_error      (reset_error),
      .rx               (chk_stream.sink),
      .frame_error      (frame_error)
   );

   stats_serializer stats_i (
      .tx_clk0          (tx_clk0),
      .reset            (reset),
      .stats_word       (stats_word),
      .stats_valid      (stats_valid),
      .serial_out       (tx_statistics_vector)
   );

endmodule

/* stats_serializer.sv */
// single-pin statistics serialiser with a leading start marker
`timescale 1ns/100ps
`include "eth_example_config.svh"

module stats_serializer (
   input  logic                        tx_clk0,
   input  logic                        reset,
   input  eth_example_pkg::tx_stats_t  stats_word,
   input  logic                        stats_valid,
   output logic                        serial_out
);

   localparam int START_W = `ETH_STATS_START;
   localparam int SHIFT_W = START_W + $bits(eth_example_pkg::tx_stats_t);

   logic [SHIFT_W-1:0] shift_reg;

   // --------------------------------------------------
   // shift register
   // --------------------------------------------------
   // marker reads 0 then 1, then the word goes out msb first
   always_ff @(posedge tx_clk0) begin
      if (reset) begin
         shift_reg <= '0;
      end else if (stats_valid) begin
         shift_reg <= {{(START_W-1){1'b0}}, 1'b1, stats_word};
      end else begin
         shift_reg <= {shift_reg[SHIFT_W-2:0], 1'b0};
      end
   end

   // line idles low once the word has drained
   assign serial_out = shift_reg[SHIFT_W-1];

endmodule

/* frame_check.sv */
// frame pattern checker that rebuilds the expected stream and holds a sticky error
`timescale 1ns/100ps
`include "eth_example_config.svh"

module frame_check (
   input  logic  tx_clk0,
   input  logic  reset,
   input  logic  enable_pat_check,
   input  logic  reset_error,
   axis_if.sink  rx,
   output logic  frame_error
);

   localparam eth_example_pkg::frame_len_t MIN_SIZE = `ETH_MIN_FRAME;

   eth_example_pkg::check_state_t state;
   eth_example_pkg::frame_len_t   exp_size;
   eth_example_pkg::frame_len_t   base;
   eth_example_pkg::axis_data_t   exp_data;
   eth_example_pkg::axis_data_t   byte_mask;
   eth_example_pkg::axis_keep_t   exp_keep;
   logic [11:0]                   beat_idx;
   logic [11:0]                   cur_beat;
   logic                          exp_last;
   logic                          xfer;
   logic                          mismatch;

   // never back-pressures
   assign rx.tready = 1'b1;

   assign xfer = rx.tvalid && rx.tready;

   // --------------------------------------------------
   // expected beat
   // --------------------------------------------------
   // first beat of a frame is whatever arrives while waiting
   assign cur_beat = (state == eth_example_pkg::CHK_WAIT) ? 12'd0 : beat_idx;
   assign base     = {cur_beat, 3'b000};
   assign exp_data = eth_example_pkg::beat_data(exp_size, base);
   assign exp_keep = eth_example_pkg::beat_keep(exp_size, base);
   assign exp_last = eth_example_pkg::beat_last(exp_size, base);

   always_comb begin
      for (int b = 0; b < 8; b++) begin
         byte_mask[8*b +: 8] = {8{exp_keep[b]}};
      end
   end

   // data is only compared on lanes that should carry frame bytes
   assign mismatch = (((rx.tdata ^ exp_data) & byte_mask) != '0) ||
                     (rx.tkeep != exp_keep) ||
                     (rx.tlast != exp_last);

   // --------------------------------------------------
   // frame tracking
   // --------------------------------------------------
   // expected size moves on every received frame, checked or not
   always_ff @(posedge tx_clk0) begin
      if (reset) begin
         state    <= eth_example_pkg::CHK_WAIT;
         exp_size <= MIN_SIZE;
         beat_idx <= '0;
      end else if (xfer) begin
         if (rx.tlast) begin
            state    <= eth_example_pkg::CHK_WAIT;
            exp_size <= eth_example_pkg::next_size(exp_size);
         end else begin
            state    <= eth_example_pkg::CHK_FRAME;
            beat_idx <= cur_beat + 12'd1;
         end
      end
   end

   // sticky error, clear request wins over a new mismatch
   always_ff @(posedge tx_clk0) begin
      if (reset) begin
         frame_error <= 1'b0;
      end else if (reset_error) begin
         frame_error <= 1'b0;
      end else if (xfer && mismatch && enable_pat_check) begin
         frame_error <= 1'b1;
      end
   end

endmodule

/* frame_gen.sv */
// frame pattern generator with error injection and per-frame statistics
`timescale 1ns/100ps
`include "eth_example_config.svh"

module frame_gen (
   input  logic                        tx_clk0,
   input  logic                        reset,
   input  logic                        enable_pat_gen,
   input  logic                        insert_error,
   axis_if.source                      tx,
   output eth_example_pkg::tx_stats_t  stats_word,
   output logic                        stats_valid
);

   localparam eth_example_pkg::frame_len_t MIN_SIZE = `ETH_MIN_FRAME;
   localparam logic [7:0] GAP_LOAD = 8'(`ETH_IFG_CYCLES - 1);

   // payload byte 0 is frame byte 14, lane 6 of beat 1
   localparam eth_example_pkg::axis_data_t ERR_MASK = 64'h00FF_0000_0000_0000;

   eth_example_pkg::gen_state_t  state;
   eth_example_pkg::frame_len_t  cur_size;
   eth_example_pkg::frame_len_t  base;
   logic [11:0]                  beat_idx;
   logic [7:0]                   gap_cnt;
   logic                         err_pending;
   logic                         err_frame;
   logic                         start;
   logic                         xfer;
   logic                         frame_done;

   // --------------------------------------------------
   // beat construction
   // --------------------------------------------------
   assign base       = {beat_idx, 3'b000};
   assign start      = (state == eth_example_pkg::GEN_IDLE) && enable_pat_gen;
   assign xfer       = tx.tvalid && tx.tready;
   assign frame_done = xfer && tx.tlast;

   // fields only move on a transfer, so they hold while stalled
   assign tx.tvalid = (state == eth_example_pkg::GEN_SEND);
   assign tx.tkeep  = eth_example_pkg::beat_keep(cur_size, base);
   assign tx.tlast  = eth_example_pkg::beat_last(cur_size, base);
   assign tx.tdata  = eth_example_pkg::beat_data(cur_size, base) ^
                      ((err_frame && beat_idx == 12'd1) ? ERR_MASK : '0);

   // --------------------------------------------------
   // frame sequencing
   // --------------------------------------------------
   always_ff @(posedge tx_clk0) begin
      if (reset) begin
         state       <= eth_example_pkg::GEN_IDLE;
         cur_size    <= MIN_SIZE;
         beat_idx    <= '0;
         gap_cnt     <= '0;
         err_pending <= 1'b0;
         err_frame   <= 1'b0;
         stats_valid <= 1'b0;
      end else begin
         stats_valid <= 1'b0;
         // a request waits here until the next frame starts
         err_pending <= (err_pending | insert_error) & ~start;
         case (state)
            eth_example_pkg::GEN_IDLE: begin
               if (start) begin
                  state     <= eth_example_pkg::GEN_SEND;
                  beat_idx  <= '0;
                  err_frame <= err_pending | insert_error;
               end
            end
            eth_example_pkg::GEN_SEND: begin
               if (frame_done) begin
                  state       <= eth_example_pkg::GEN_GAP;
                  gap_cnt     <= GAP_LOAD;
                  stats_valid <= 1'b1;
                  cur_size    <= eth_example_pkg::next_size(cur_size);
               end else if (xfer) begin
                  beat_idx <= beat_idx + 12'd1;
               end
            end
            eth_example_pkg::GEN_GAP: begin
               if (gap_cnt == 8'd0) begin
                  state <= eth_example_pkg::GEN_IDLE;
               end else begin
                  gap_cnt <= gap_cnt - 8'd1;
               end
            end
            default: state <= eth_example_pkg::GEN_IDLE;
         endcase
      end
   end

   // stats word captured as the last beat leaves
   always_ff @(posedge tx_clk0) begin
      if (frame_done) begin
         stats_word <= {err_frame, cur_size};
      end
   end

endmodule

/* axis_if.sv */
// 64-bit stream interface with byte keeps, valid/ready handshake and modports
`timescale 1ns/100ps

interface axis_if;

   eth_example_pkg::axis_data_t tdata;
   eth_example_pkg::axis_keep_t tkeep;
   logic                        tvalid;
   logic                        tlast;
   logic                        tready;

   // frame producer side
   modport source (
      output tdata, tkeep, tvalid, tlast,
      input  tready
   );

   // frame consumer side
   modport sink (
      input  tdata, tkeep, tvalid, tlast,
      output tready
   );

   // passive observer
   modport monitor (
      input  tdata, tkeep, tvalid, tlast, tready
   );

endinterface

/* eth_example_pkg.sv */
// stream and frame types, state enums and the shared frame rule helpers
`include "eth_example_config.svh"

package eth_example_pkg;

   typedef logic [63:0] axis_data_t;
   typedef logic [7:0]  axis_keep_t;
   typedef logic [47:0] mac_addr_t;
   typedef logic [14:0] frame_len_t;
   // bit 15 error inserted, bits 14:0 frame length
   typedef logic [15:0] tx_stats_t;

   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_SEND,
      GEN_GAP
   } gen_state_t;

   typedef enum logic {
      CHK_WAIT,
      CHK_FRAME
   } check_state_t;

   // --------------------------------------------------
   // frame rule
   // --------------------------------------------------
   // dest in bytes 0-5, src in 6-11, payload length in 12-13, then i mod 256
   function automatic axis_data_t beat_data(frame_len_t size, frame_len_t base);
      frame_len_t pos;
      frame_len_t pay_len;
      frame_len_t pay_idx;
      logic [2:0] sel;
      mac_addr_t  dest;
      mac_addr_t  src;
      axis_data_t data;
      dest    = `ETH_DEST_ADDR;
      src     = `ETH_SRC_ADDR;
      pay_len = size - 15'd14;
      data    = '0;
      for (int b = 0; b < 8; b++) begin
         pos     = base + 15'(b);
         pay_idx = pos - 15'd14;
         if (pos >= size) begin
            data[8*b +: 8] = 8'h00;
         end else if (pos < 15'd6) begin
            sel            = pos[2:0];
            data[8*b +: 8] = dest[8*sel +: 8];
         end else if (pos < 15'd12) begin
            sel            = 3'(pos - 15'd6);
            data[8*b +: 8] = src[8*sel +: 8];
         end else if (pos == 15'd12) begin
            // length goes out high byte first
            data[8*b +: 8] = {1'b0, pay_len[14:8]};
         end else if (pos == 15'd13) begin
            data[8*b +: 8] = pay_len[7:0];
         end else begin
            data[8*b +: 8] = pay_idx[7:0];
         end
      end
      return data;
   endfunction

   function automatic axis_keep_t beat_keep(frame_len_t size, frame_len_t base);
      axis_keep_t keep;
      for (int b = 0; b < 8; b++) begin
         keep[b] = (base + 15'(b)) < size;
      end
      return keep;
   endfunction

   function automatic logic beat_last(frame_len_t size, frame_len_t base);
      return (base + 15'd8) >= size;
   endfunction

   // sizes count up by one and wrap from max back to min
   function automatic frame_len_t next_size(frame_len_t size);
      if (size >= frame_len_t'(`ETH_MAX_FRAME)) begin
         return frame_len_t'(`ETH_MIN_FRAME);
      end
      return size + 15'd1;
   endfunction

endpackage

/* eth_example_config.svh */
// addresses, frame size limits, inter-frame gap and stats marker width
`ifndef ETH_EXAMPLE_CONFIG_SVH
`define ETH_EXAMPLE_CONFIG_SVH

// --------------------------------------------------
// frame addressing
// --------------------------------------------------
// first byte on the wire sits in the low bits
`define ETH_DEST_ADDR      48'h0504030201DA
`define ETH_SRC_ADDR       48'h05040302015A

// --------------------------------------------------
// frame sizing and spacing
// --------------------------------------------------
// sizes in bytes, including the 14-byte header
`define ETH_MIN_FRAME      64
`define ETH_MAX_FRAME      200

// idle cycles after the last beat of every frame
`define ETH_IFG_CYCLES     12

// width of the 0-then-1 marker ahead of each stats word
`define ETH_STATS_START    2

`endif
